// File: hdl/aes_consts.svh
/* round count and key schedule cycle counts for the AES-128 engine */
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// cipher rounds for a 128-bit key
`define AES_ROUNDS 10

// forward schedule steps needed before decryption can start
`define AES_KEY_FWD_CYCLES 10

`endif

// File: hdl/aesPkg.sv
/* shared AES types: block, word, byte, round index and control state */
package aesPkg;

  // 16 bytes column-major, byte 0 (row 0, col 0) in bits 127:120
  typedef logic [127:0] blockT;

  // one schedule word or one state column, row 0 in the top byte
  typedef logic [31:0] wordT;

  // state byte, S-box value or round constant
  typedef logic [7:0] byteT;

  // round and key-step counter
  typedef logic [3:0] roundIdxT;

  // sequencer states
  typedef enum logic [1:0] {
    sIdle,
    sKeyFwd,
    sRound
  } aesStateE;

endpackage

// File: hdl/aesSbox.sv
/* AES S-box byte substitution, forward or inverse, from GF(2^8) inversion
   and the affine map */
`timescale 1ns/1ps

module aesSbox (
  input  aesPkg::byteT inByte,
  input  logic         inverse,
  output aesPkg::byteT outByte
);
  import aesPkg::*;

  // multiply modulo x^8 + x^4 + x^3 + x + 1
  function automatic byteT gfMul(input byteT a, input byteT b);
    byteT p;
    byteT x;
    int   i;
    p = '0;
    x = a;
    for (i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ x;
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // a^254 is the multiplicative inverse, zero stays zero
  function automatic byteT gfInv(input byteT a);
    byteT a2, a3, a6, a12, a15, a30, a60, a120, a240, a252;
    a2   = gfMul(a, a);
    a3   = gfMul(a2, a);
    a6   = gfMul(a3, a3);
    a12  = gfMul(a6, a6);
    a15  = gfMul(a12, a3);
    a30  = gfMul(a15, a15);
    a60  = gfMul(a30, a30);
    a120 = gfMul(a60, a60);
    a240 = gfMul(a120, a120);
    a252 = gfMul(a240, a12);
    return gfMul(a252, a2);
  endfunction

  byteT preInv;
  byteT invVal;
  byteT fwdAffine;

  // inverse mode undoes the affine map before inversion
  // rotations by 1, 3 and 6 plus constant 05
  assign preInv = inverse ?
                  ({inByte[6:0], inByte[7]} ^ {inByte[4:0], inByte[7:5]} ^
                   {inByte[1:0], inByte[7:2]} ^ 8'h05) :
                  inByte;

  assign invVal = gfInv(preInv);

  // forward affine, byte xor its rotations by 1 to 4 plus constant 63
  assign fwdAffine = invVal ^ {invVal[6:0], invVal[7]} ^ {invVal[5:0], invVal[7:6]} ^
                     {invVal[4:0], invVal[7:5]} ^ {invVal[3:0], invVal[7:4]} ^ 8'h63;

  assign outByte = inverse ? invVal : fwdAffine;

endmodule

// File: hdl/aesKeyExpand.sv
/* on-the-fly AES-128 key schedule, stepping forward or in reverse,
   with its own round constant register */
`timescale 1ns/1ps

module aesKeyExpand (
  input  logic          clk,
  input  logic          arstN,
  input  aesPkg::blockT key,
  input  logic          keyLoad,
  input  logic          keyStepFwd,
  input  logic          keyStepRev,
  output aesPkg::blockT roundKey
);
  import aesPkg::*;

  blockT keyQ;
  blockT keyFwd;
  blockT keyRev;
  blockT keyNext;
  wordT  w0, w1, w2, w3;
  wordT  n0, n1, n2, n3;
  wordT  subSrc, rotWord, subWord, tWord;
  byteT  rconQ, rconDbl, rconHalf, rconUse;

  assign {w0, w1, w2, w3} = keyQ;

  // rcon times x, and rcon divided by x
  assign rconDbl  = {rconQ[6:0], 1'b0} ^ (rconQ[7] ? 8'h1b : 8'h00);
  assign rconHalf = {1'b0, rconQ[7:1]} ^ (rconQ[0] ? 8'h8d : 8'h00);

  // reverse step needs the previous w3, which is w3 ^ w2
  assign subSrc  = keyStepRev ? (w3 ^ w2) : w3;
  assign rotWord = {subSrc[23:0], subSrc[31:24]};
  assign rconUse = keyStepRev ? rconHalf : rconQ;

  // SubWord, one forward S-box per byte
  for (genvar i = 0; i < 4; i++) begin : gSubWord
    aesSbox u_aesSbox (
      .inByte  (rotWord[31-8*i -: 8]),
      .inverse (1'b0),
      .outByte (subWord[31-8*i -: 8])
    );
  end

  assign tWord = subWord ^ {rconUse, 24'h000000};

  // forward, each word chains off the one before
  assign n0 = w0 ^ tWord;
  assign n1 = w1 ^ n0;
  assign n2 = w2 ^ n1;
  assign n3 = w3 ^ n2;
  assign keyFwd = {n0, n1, n2, n3};

  // reverse, undo the chaining then recompute word 0
  assign keyRev = {w0 ^ tWord, w1 ^ w0, w2 ^ w1, w3 ^ w2};

  assign keyNext = keyLoad    ? key    :
                   keyStepFwd ? keyFwd :
                   keyStepRev ? keyRev : keyQ;

  // datapath sees the key that is valid after this edge
  assign roundKey = keyNext;

  always_ff @(posedge clk) begin
    keyQ <= keyNext;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rconQ <= 8'h01;
    end else if (keyLoad) begin
      rconQ <= 8'h01;
    end else if (keyStepFwd) begin
      rconQ <= rconDbl;
    end else if (keyStepRev) begin
      rconQ <= rconHalf;
    end
  end

endmodule

// File: hdl/aesRound.sv
/* AES state register with the shared forward and inverse round datapath */
`timescale 1ns/1ps

module aesRound (
  input  logic          clk,
  input  logic          arstN,
  input  aesPkg::blockT dataIn,
  input  aesPkg::blockT roundKey,
  input  logic          decrypt,
  input  logic          stateLoad,
  input  logic          roundEn,
  input  logic          lastRound,
  output aesPkg::blockT state
);
  import aesPkg::*;

  function automatic byteT xtime(input byteT b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // ShiftRows rotates row r left by r, the inverse rotates right
  function automatic blockT shiftRows(input blockT b, input logic inv);
    blockT res;
    int    r;
    int    c;
    int    srcCol;
    res = '0;
    for (r = 0; r < 4; r++) begin
      for (c = 0; c < 4; c++) begin
        srcCol = inv ? (c - r + 4) % 4 : (c + r) % 4;
        res[127-8*(r+4*c) -: 8] = b[127-8*(r+4*srcCol) -: 8];
      end
    end
    return res;
  endfunction

  // inverse column mix is a small pre-mix followed by the forward one
  function automatic wordT mixColumn(input wordT col, input logic inv);
    byteT a0, a1, a2, a3, t, u, v;
    {a0, a1, a2, a3} = col;
    if (inv) begin
      u  = xtime(xtime(a0 ^ a2));
      v  = xtime(xtime(a1 ^ a3));
      a0 = a0 ^ u;
      a1 = a1 ^ v;
      a2 = a2 ^ u;
      a3 = a3 ^ v;
    end
    t = a0 ^ a1 ^ a2 ^ a3;
    return {a0 ^ t ^ xtime(a0 ^ a1), a1 ^ t ^ xtime(a1 ^ a2),
            a2 ^ t ^ xtime(a2 ^ a3), a3 ^ t ^ xtime(a3 ^ a0)};
  endfunction

  blockT subBytes;
  blockT shifted;
  blockT keyed;
  blockT mixIn;
  blockT mixOut;
  blockT fwdOut;
  blockT invOut;
  blockT roundOut;

  // substitution and row shift commute, so one S-box bank serves both directions
  for (genvar i = 0; i < 16; i++) begin : gSubBytes
    aesSbox u_aesSbox (
      .inByte  (state[127-8*i -: 8]),
      .inverse (decrypt),
      .outByte (subBytes[127-8*i -: 8])
    );
  end

  assign shifted = shiftRows(subBytes, decrypt);
  assign keyed   = shifted ^ roundKey;

  // forward mixes before the key, inverse after it
  assign mixIn = decrypt ? keyed : shifted;
  for (genvar c = 0; c < 4; c++) begin : gMix
    assign mixOut[127-32*c -: 32] = mixColumn(mixIn[127-32*c -: 32], decrypt);
  end

  // final round drops the column mix
  assign fwdOut   = (lastRound ? shifted : mixOut) ^ roundKey;
  assign invOut   = lastRound ? keyed : mixOut;
  assign roundOut = decrypt ? invOut : fwdOut;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= '0;
    end else if (stateLoad) begin
      // initial AddRoundKey
      state <= dataIn ^ roundKey;
    end else if (roundEn) begin
      state <= roundOut;
    end
  end

endmodule

// File: hdl/aesControl.sv
/* AES sequencer, FSM and round counter for key expansion and rounds */
`timescale 1ns/1ps
`include "aes_consts.svh"

module aesControl (
  input  logic clk,
  input  logic arstN,
  input  logic start,
  input  logic dir,
  output logic keyLoad,
  output logic keyStepFwd,
  output logic keyStepRev,
  output logic stateLoad,
  output logic roundEn,
  output logic lastRound,
  output logic decrypt,
  output logic busy,
  output logic done
);
  import aesPkg::*;

  aesStateE stateQ;
  roundIdxT cntQ;
  logic     accept;
  logic     keyFwdLast;

  // start only counts while idle
  assign accept     = start && (stateQ == sIdle);
  assign keyFwdLast = (stateQ == sKeyFwd) && (cntQ == roundIdxT'(`AES_KEY_FWD_CYCLES));

  // count 0 in sRound is the decrypt initial key add
  assign roundEn    = (stateQ == sRound) && (cntQ != '0);
  assign lastRound  = (stateQ == sRound) && (cntQ == roundIdxT'(`AES_ROUNDS));

  assign keyLoad    = accept;
  // encrypt loads the state on the start edge itself
  assign stateLoad  = (accept && !dir) || ((stateQ == sRound) && (cntQ == '0));
  assign keyStepFwd = (stateQ == sKeyFwd) || (roundEn && !decrypt);
  assign keyStepRev = roundEn && decrypt;
  assign busy       = (stateQ != sIdle);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      stateQ  <= sIdle;
      cntQ    <= '0;
      decrypt <= 1'b0;
      done    <= 1'b0;
    end else begin
      // one-cycle pulse after the last round edge
      done <= lastRound;
      case (stateQ)
        sIdle: begin
          if (accept) begin
            decrypt <= dir;
            cntQ    <= roundIdxT'(1);
            stateQ  <= dir ? sKeyFwd : sRound;
          end
        end
        sKeyFwd: begin
          if (keyFwdLast) begin
            cntQ   <= '0;
            stateQ <= sRound;
          end else begin
            cntQ <= cntQ + 1'b1;
          end
        end
        sRound: begin
          if (lastRound) begin
            cntQ   <= '0;
            stateQ <= sIdle;
          end else begin
            cntQ <= cntQ + 1'b1;
          end
        end
        default: stateQ <= sIdle;
      endcase
    end
  end

endmodule

// File: hdl/aesCore.sv
/* AES-128 engine top, ties the sequencer, key schedule and round datapath */
`timescale 1ns/1ps

module aesCore (
  input  logic          clk,
  input  logic          arstN,
  input  logic          start,
  input  logic          dir,
  input  aesPkg::blockT key,
  input  aesPkg::blockT dataIn,
  output logic          busy,
  output logic          done,
  output aesPkg::blockT dataOut
);
  import aesPkg::*;

  logic  keyLoad;
  logic  keyStepFwd;
  logic  keyStepRev;
  logic  stateLoad;
  logic  roundEn;
  logic  lastRound;
  logic  decrypt;
  blockT roundKey;

  aesControl u_aesControl (
    .clk        (clk),
    .arstN      (arstN),
    .start      (start),
    .dir        (dir),
    .keyLoad    (keyLoad),
    .keyStepFwd (keyStepFwd),
    .keyStepRev (keyStepRev),
    .stateLoad  (stateLoad),
    .roundEn    (roundEn),
    .lastRound  (lastRound),
    .decrypt    (decrypt),
    .busy       (busy),
    .done       (done)
  );

  aesKeyExpand u_aesKeyExpand (
    .clk        (clk),
    .arstN      (arstN),
    .key        (key),
    .keyLoad    (keyLoad),
    .keyStepFwd (keyStepFwd),
    .keyStepRev (keyStepRev),
    .roundKey   (roundKey)
  );

  // state register is the result, held until the next accepted start
  aesRound u_aesRound (
    .clk       (clk),
    .arstN     (arstN),
    .dataIn    (dataIn),
    .roundKey  (roundKey),
    .decrypt   (decrypt),
    .stateLoad (stateLoad),
    .roundEn   (roundEn),
    .lastRound (lastRound),
    .state     (dataOut)
  );

endmodule

// File: testbench/aesCoreTb.sv
/* AES-128 engine testbench: reset state, known answers from the vector file,
   LFSR round trips and start pulses while busy */
`timescale 1ns/1ps
`include "aes_consts.svh"

module aesCoreTb;
  import aesPkg::*;

  // encrypt loads on the start edge, decrypt spends a key-forward phase and a load edge first
  // done is seen one edge after the last round edge
  localparam int encLatency = `AES_ROUNDS + 1;
  localparam int decLatency = `AES_KEY_FWD_CYCLES + `AES_ROUNDS + 2;
  localparam int opTimeout  = 64;
  localparam string vecFile = "testbench/aesVectors.txt";

  logic  clk;
  logic  arstN;
  logic  start;
  logic  dir;
  blockT key;
  blockT dataIn;
  logic  busy;
  logic  done;
  blockT dataOut;

  int          errors;
  int          timeouts;
  int          checks;
  logic [31:0] lfsrState;
  logic        vecDir[$];
  blockT       vecKey[$];
  blockT       vecIn[$];
  blockT       vecExp[$];

  aesCore u_aesCore (
    .clk     (clk),
    .arstN   (arstN),
    .start   (start),
    .dir     (dir),
    .key     (key),
    .dataIn  (dataIn),
    .busy    (busy),
    .done    (done),
    .dataOut (dataOut)
  );

  always #50 clk = ~clk;

  task automatic reportMismatch(input string name, input string expStr, input string actStr);
    errors++;
    $display("[ERROR] %s expected %s actual %s", name, expStr, actStr);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit
  task automatic randomBlock(output blockT b);
    int i;
    b = '0;
    for (i = 0; i < 128; i++) begin
      lfsrState = lfsrNext(lfsrState);
      b = {b[126:0], lfsrState[0]};
    end
  endtask

  // lines starting with # are column notes
  task automatic loadVectors();
    int         fd;
    int         n;
    string      line;
    logic [7:0] d;
    blockT      k;
    blockT      x;
    blockT      e;
    fd = $fopen(vecFile, "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the vector file %s", vecFile);
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // 8'h23 is the comment character
        if (n > 1 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%h %h %h %h", d, k, x, e);
          if (n == 4) begin
            vecDir.push_back(d[0]);
            vecKey.push_back(k);
            vecIn.push_back(x);
            vecExp.push_back(e);
          end else begin
            errors++;
            $display("malformed line in the vector file: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    if (vecKey.size() == 0) begin
      errors++;
      $display("the vector file holds no vectors");
    end
  endtask

  // one request, optional second start pulse after injectAt sampled cycles
  task automatic runOp(input string name, input logic dirV, input blockT keyV,
                       input blockT dataV, input int injectAt, input logic altDir,
                       input blockT altKey, input blockT altData,
                       output blockT result, output int latency);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    @(posedge clk);
    start  <= 1'b1;
    dir    <= dirV;
    key    <= keyV;
    dataIn <= dataV;
    // DUT samples start on this edge
    @(posedge clk);
    start <= 1'b0;
    while (!seen && cycles < opTimeout) begin
      @(negedge clk);
      cycles++;
      if (done) begin
        seen = 1'b1;
      end else begin
        // busy stays high until the result is out
        checks++;
        if (busy !== 1'b1) begin
          reportMismatch({name, " busy"}, "1", $sformatf("%b", busy));
        end
        @(posedge clk);
        if (cycles == injectAt) begin
          start  <= 1'b1;
          dir    <= altDir;
          key    <= altKey;
          dataIn <= altData;
        end else begin
          start <= 1'b0;
        end
      end
    end
    if (!seen) begin
      timeouts++;
      $display("%s: done never arrived within %0d cycles", name, opTimeout);
    end
    result  = dataOut;
    latency = cycles;
  endtask

  task automatic checkOp(input string name, input blockT expData, input blockT actData,
                         input int expLat, input int actLat);
    checks += 2;
    if (actData !== expData) begin
      reportMismatch({name, " data"}, $sformatf("%h", expData), $sformatf("%h", actData));
    end
    if (actLat != expLat) begin
      reportMismatch({name, " latency"}, $sformatf("%0d", expLat), $sformatf("%0d", actLat));
    end
  endtask

  // fixed window after a result, no further done may show up
  task automatic checkQuiet(input string name);
    int pulses;
    int i;
    pulses = 0;
    for (i = 0; i < 2 * decLatency; i++) begin
      @(negedge clk);
      if (done) pulses++;
    end
    checks++;
    if (pulses != 0) begin
      reportMismatch(name, "0 extra done pulses", $sformatf("%0d", pulses));
    end
  endtask

  initial begin
    blockT res;
    blockT back;
    blockT rKey;
    blockT rPlain;
    blockT altKey;
    blockT altData;
    int    lat;
    int    encIdx;
    int    decIdx;
    clk       = 1'b0;
    arstN     = 1'b0;
    start     = 1'b0;
    dir       = 1'b0;
    key       = '0;
    dataIn    = '0;
    errors    = 0;
    timeouts  = 0;
    checks    = 0;
    lfsrState = 32'hb96d_d5f5;
    encIdx    = -1;
    decIdx    = -1;
    loadVectors();
    repeat (16) @(posedge clk);
    arstN <= 1'b1;

    // idle after reset, result register cleared
    @(negedge clk);
    checks += 2;
    if (busy !== 1'b0 || done !== 1'b0) begin
      reportMismatch("reset busy and done", "00", $sformatf("%b%b", busy, done));
    end
    if (dataOut !== '0) begin
      reportMismatch("reset dataOut", $sformatf("%h", blockT'(0)), $sformatf("%h", dataOut));
    end

    // known answers in both directions
    foreach (vecKey[i]) begin
      runOp($sformatf("vector %0d", i), vecDir[i], vecKey[i], vecIn[i], 0, 1'b0, '0, '0,
            res, lat);
      checkOp($sformatf("%s vector %0d", vecDir[i] ? "dec" : "enc", i), vecExp[i], res,
              vecDir[i] ? decLatency : encLatency, lat);
      if (!vecDir[i] && encIdx < 0) encIdx = i;
      if (vecDir[i] && decIdx < 0) decIdx = i;
    end

    // encrypt then decrypt must give the plaintext back
    for (int n = 0; n < 32; n++) begin
      randomBlock(rKey);
      randomBlock(rPlain);
      runOp($sformatf("trip %0d enc", n), 1'b0, rKey, rPlain, 0, 1'b0, '0, '0, res, lat);
      checks++;
      if (lat != encLatency) begin
        reportMismatch($sformatf("trip %0d enc latency", n), $sformatf("%0d", encLatency),
                       $sformatf("%0d", lat));
      end
      runOp($sformatf("trip %0d dec", n), 1'b1, rKey, res, 0, 1'b0, '0, '0, back, lat);
      checkOp($sformatf("trip %0d", n), rPlain, back, decLatency, lat);
    end

    // second start mid-operation with other inputs is ignored
    // decrypt pulse comes after the state load since dataIn is sampled there
    if (encIdx < 0 || decIdx < 0) begin
      errors++;
      $display("start-while-busy test needs one encryption and one decryption vector");
    end else begin
      randomBlock(altKey);
      randomBlock(altData);
      runOp("busy enc", 1'b0, vecKey[encIdx], vecIn[encIdx], 5, 1'b1, altKey, altData,
            res, lat);
      checkOp("busy enc", vecExp[encIdx], res, encLatency, lat);
      checkQuiet("busy enc done count");
      runOp("busy dec", 1'b1, vecKey[decIdx], vecIn[decIdx], 14, 1'b0, altKey, altData,
            res, lat);
      checkOp("busy dec", vecExp[decIdx], res, decLatency, lat);
      checkQuiet("busy dec done count");
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/aesVectors.txt
# columns: dir key input expected, all hex
# dir 0 encrypts, dir 1 decrypts
0 2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
0 000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
0 00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
0 2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
1 2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734
1 000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
1 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 00000000000000000000000000000000
1 2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a

// File: vlog.f
+incdir+hdl
hdl/aesPkg.sv
hdl/aesSbox.sv
hdl/aesKeyExpand.sv
hdl/aesRound.sv
hdl/aesControl.sv
hdl/aesCore.sv
testbench/aesCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= aesCoreTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
